//--- rtl/ex_pkg.sv
`default_nettype none

package ex_pkg;

  // Data path width
  localparam int unsigned XLEN = 32;

  // Operand and result word
  typedef logic [XLEN-1:0] word_t;

  // Shift amount, wide enough for a full 32 place shift
  typedef logic [5:0] shamt_t;

  // Leading/trailing zero and population counts, 0 to 32
  typedef logic [5:0] bitcnt_t;

  ////////////////////////////////////////////////////////////////////////////
  // Operators
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [5:0] {
    // Base integer set
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
    ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLTS, ALU_SLTU, ALU_EQ, ALU_NE,
    ALU_LTS, ALU_LTU, ALU_GES, ALU_GEU,
    // Zba
    ALU_B_SH1ADD, ALU_B_SH2ADD, ALU_B_SH3ADD,
    // Zbb
    ALU_B_CLZ, ALU_B_CTZ, ALU_B_CPOP, ALU_B_MIN,
    ALU_B_MINU, ALU_B_MAX, ALU_B_MAXU, ALU_B_ANDN,
    ALU_B_ORN, ALU_B_XNOR, ALU_B_ORC_B, ALU_B_REV8,
    ALU_B_ROL, ALU_B_ROR, ALU_B_SEXT_B, ALU_B_SEXT_H,
    // Zbs
    ALU_B_BSET, ALU_B_BCLR, ALU_B_BINV, ALU_B_BEXT,
    // RV32M division and remainder
    ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU
  } alu_opcode_e;

  ////////////////////////////////////////////////////////////////////////////
  // Request and response
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    alu_opcode_e operator;
    word_t       operand_a;
    word_t       operand_b;
  } ex_req_t;

  typedef struct packed {
    word_t result;
    // Branch comparison outcome
    logic  cmp;
  } ex_rsp_t;

endpackage

`default_nettype wire

//--- rtl/ff_one.sv
`default_nettype none

module ff_one (
  input  ex_pkg::word_t in_i,
  output logic [4:0]    first_one_o,
  output logic          no_ones_o
);

  import ex_pkg::*;

  // Heap ordered binary tree, node n has children 2n+1 and 2n+2
  // Leaves sit at XLEN-1 and up, leaf XLEN-1 holds bit 0
  logic [4:0] node_idx [2*XLEN-1];
  logic       node_vld [2*XLEN-1];

  for (genvar j = 0; j < XLEN; j++) begin : gen_leaf
    assign node_vld[XLEN-1+j] = in_i[j];
    assign node_idx[XLEN-1+j] = 5'(j);
  end

  // Left child covers the lower bits, so it wins when set
  for (genvar n = 0; n < XLEN - 1; n++) begin : gen_node
    assign node_vld[n] = node_vld[2*n+1] | node_vld[2*n+2];
    assign node_idx[n] = node_vld[2*n+1] ? node_idx[2*n+1] : node_idx[2*n+2];
  end

  assign first_one_o = node_idx[0];
  assign no_ones_o   = ~node_vld[0];

endmodule

`default_nettype wire

//--- rtl/alu_b_cpop.sv
`default_nettype none

module alu_b_cpop (
  input  ex_pkg::word_t   operand_i,
  output ex_pkg::bitcnt_t result_o
);

  // Partial sums widen by one bit per level
  logic [1:0] sum_2 [16];
  logic [2:0] sum_4 [8];
  logic [3:0] sum_8 [4];
  logic [4:0] sum_16 [2];

  for (genvar i = 0; i < 16; i++) begin : gen_lvl1
    assign sum_2[i] = {1'b0, operand_i[2*i]} + {1'b0, operand_i[2*i+1]};
  end
  for (genvar i = 0; i < 8; i++) begin : gen_lvl2
    assign sum_4[i] = {1'b0, sum_2[2*i]} + {1'b0, sum_2[2*i+1]};
  end
  for (genvar i = 0; i < 4; i++) begin : gen_lvl3
    assign sum_8[i] = {1'b0, sum_4[2*i]} + {1'b0, sum_4[2*i+1]};
  end
  for (genvar i = 0; i < 2; i++) begin : gen_lvl4
    assign sum_16[i] = {1'b0, sum_8[2*i]} + {1'b0, sum_8[2*i+1]};
  end

  assign result_o = {1'b0, sum_16[0]} + {1'b0, sum_16[1]};

endmodule

`default_nettype wire

//--- rtl/alu.sv
`default_nettype none

module alu (
  input  ex_pkg::alu_opcode_e operator_i,
  input  ex_pkg::word_t       operand_a_i,
  input  ex_pkg::word_t       operand_b_i,
  output ex_pkg::word_t       result_o,
  output logic                comparison_result_o,

  // Divider access to the leading zero count
  input  logic                div_clz_en_i,
  input  ex_pkg::word_t       div_clz_data_i,
  output ex_pkg::bitcnt_t     div_clz_result_o,

  // Divider access to the shifter
  input  logic                div_shift_en_i,
  input  ex_pkg::shamt_t      div_shift_amt_i,
  input  ex_pkg::word_t       div_shift_data_i,
  output ex_pkg::word_t       div_shifted_o
);

  import ex_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Adder
  ////////////////////////////////////////////////////////////////////////////

  logic              adder_negate;
  word_t             adder_op_a;
  word_t             adder_op_b;
  logic [XLEN+1:0]   adder_sum;
  word_t             adder_result;

  assign adder_negate = (operator_i == ALU_SUB);

  // Zba pre-shifts operand a into the same adder
  always_comb begin
    unique case (operator_i)
      ALU_B_SH1ADD: adder_op_a = {operand_a_i[XLEN-2:0], 1'b0};
      ALU_B_SH2ADD: adder_op_a = {operand_a_i[XLEN-3:0], 2'b0};
      ALU_B_SH3ADD: adder_op_a = {operand_a_i[XLEN-4:0], 3'b0};
      default:      adder_op_a = operand_a_i;
    endcase
  end

  assign adder_op_b = adder_negate ? ~operand_b_i : operand_b_i;

  // Extra low bit carries the +1 of the two's complement
  assign adder_sum    = {1'b0, adder_op_a, 1'b1} + {1'b0, adder_op_b, adder_negate};
  assign adder_result = adder_sum[XLEN:1];

  ////////////////////////////////////////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic arith;
    logic rotate;
    logic single;
    logic rshift;
  } shift_ctrl_t;

  shift_ctrl_t       sh_ctrl;
  shamt_t            sh_amt;
  word_t             sh_aa;
  word_t             sh_bb;
  logic [2*XLEN-1:0] sh_tmp;
  word_t             sh_x;

  // Control fields, MSB first: arith, rotate, single, rshift
  always_comb begin
    unique case (operator_i)
      ALU_SRL:    sh_ctrl = 4'b0001;
      ALU_SRA:    sh_ctrl = 4'b1001;
      ALU_B_ROL:  sh_ctrl = 4'b1100;
      ALU_B_ROR:  sh_ctrl = 4'b1101;
      ALU_B_BSET: sh_ctrl = 4'b0110;
      ALU_B_BCLR: sh_ctrl = 4'b1010;
      ALU_B_BINV: sh_ctrl = 4'b1110;
      ALU_B_BEXT: sh_ctrl = 4'b1011;
      default:    sh_ctrl = 4'b0000;
    endcase
    // Divider normalisation is always a plain left shift
    if (div_shift_en_i) begin
      sh_ctrl = '0;
    end
  end

  always_comb begin
    sh_amt = div_shift_en_i ? div_shift_amt_i : shamt_t'(operand_b_i[4:0]);
    // Right shift as left rotate by the negated amount
    if (sh_ctrl.rshift) begin
      sh_amt = -sh_amt;
    end
    sh_aa = div_shift_en_i ? div_shift_data_i : operand_a_i;
    // Upper half fills zeros, sign or the word itself
    sh_bb = !sh_ctrl.arith ? '0 : sh_ctrl.rotate ? operand_a_i : {XLEN{operand_a_i[XLEN-1]}};
    // Single bit set/clear/invert build a one-hot mask
    if (sh_ctrl.single && !sh_ctrl.rshift) begin
      sh_aa = word_t'(1);
      sh_bb = '0;
    end
    // 64 bit rotate, one stage per amount bit
    sh_tmp = {sh_bb, sh_aa};
    for (int i = 0; i < 6; i++) begin
      if (sh_amt[i]) begin
        sh_tmp = (sh_tmp << (2 ** i)) | (sh_tmp >> (2 * XLEN - 2 ** i));
      end
    end
  end

  assign sh_x          = sh_tmp[XLEN-1:0];
  assign div_shifted_o = sh_x;

  ////////////////////////////////////////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////////////////////////////////////////

  logic cmp_signed;
  logic is_equal;
  logic is_greater;

  // Shared by set-less-than, branches and min/max
  assign cmp_signed = operator_i inside {ALU_LTS, ALU_GES, ALU_SLTS, ALU_B_MIN, ALU_B_MAX};
  assign is_equal   = (operand_a_i == operand_b_i);
  assign is_greater = $signed({operand_a_i[XLEN-1] & cmp_signed, operand_a_i})
                    > $signed({operand_b_i[XLEN-1] & cmp_signed, operand_b_i});

  always_comb begin
    unique case (operator_i)
      ALU_NE:           comparison_result_o = ~is_equal;
      ALU_GES, ALU_GEU: comparison_result_o = is_greater | is_equal;
      ALU_LTS, ALU_LTU,
      ALU_SLTS, ALU_SLTU: comparison_result_o = ~(is_greater | is_equal);
      default:          comparison_result_o = is_equal;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bit counts
  ////////////////////////////////////////////////////////////////////////////

  word_t      clz_src;
  word_t      clz_rev;
  word_t      ff_in;
  logic [4:0] ff_index;
  logic       ff_none;
  bitcnt_t    cpop;
  word_t      orc_b;

  assign clz_src = div_clz_en_i ? div_clz_data_i : operand_a_i;
  assign clz_rev = {<<{clz_src}};
  // CTZ searches from bit 0 directly, CLZ on the reversed word
  assign ff_in   = (operator_i == ALU_B_CTZ && !div_clz_en_i) ? clz_src : clz_rev;

  ff_one ff_one_i (
    .in_i        (ff_in),
    .first_one_o (ff_index),
    .no_ones_o   (ff_none)
  );

  // Zero word counts as 32
  assign div_clz_result_o = ff_none ? bitcnt_t'(XLEN) : {1'b0, ff_index};

  alu_b_cpop alu_b_cpop_i (
    .operand_i (operand_a_i),
    .result_o  (cpop)
  );

  always_comb begin
    for (int i = 0; i < XLEN / 8; i++) begin
      orc_b[8*i +: 8] = {8{|operand_a_i[8*i +: 8]}};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (operator_i)
      ALU_ADD, ALU_SUB,
      ALU_B_SH1ADD, ALU_B_SH2ADD, ALU_B_SH3ADD: result_o = adder_result;
      ALU_AND:      result_o = operand_a_i & operand_b_i;
      ALU_OR:       result_o = operand_a_i | operand_b_i;
      ALU_XOR:      result_o = operand_a_i ^ operand_b_i;
      ALU_B_ANDN:   result_o = operand_a_i & ~operand_b_i;
      ALU_B_ORN:    result_o = operand_a_i | ~operand_b_i;
      ALU_B_XNOR:   result_o = operand_a_i ^ ~operand_b_i;
      ALU_SLL, ALU_SRL, ALU_SRA,
      ALU_B_ROL, ALU_B_ROR: result_o = sh_x;
      ALU_B_BSET:   result_o = operand_a_i | sh_x;
      ALU_B_BCLR:   result_o = operand_a_i & ~sh_x;
      ALU_B_BINV:   result_o = operand_a_i ^ sh_x;
      ALU_B_BEXT:   result_o = word_t'(sh_x[0]);
      ALU_SLTS, ALU_SLTU: result_o = word_t'(comparison_result_o);
      ALU_B_MIN, ALU_B_MINU: result_o = is_greater ? operand_b_i : operand_a_i;
      ALU_B_MAX, ALU_B_MAXU: result_o = is_greater ? operand_a_i : operand_b_i;
      ALU_B_CLZ, ALU_B_CTZ:  result_o = word_t'(div_clz_result_o);
      ALU_B_CPOP:   result_o = word_t'(cpop);
      ALU_B_ORC_B:  result_o = orc_b;
      ALU_B_REV8:   result_o = {<<8{operand_a_i}};
      ALU_B_SEXT_B: result_o = {{(XLEN-8){operand_a_i[7]}}, operand_a_i[7:0]};
      ALU_B_SEXT_H: result_o = {{(XLEN-16){operand_a_i[15]}}, operand_a_i[15:0]};
      // Division results come from the divider
      default:      result_o = '0;
    endcase
  end

  // Divider uses the count and the shifter in separate states
  always_comb begin
    assert (!(div_clz_en_i && div_shift_en_i))
      else $error("ALU CLZ and shift ports requested together");
  end

endmodule

`default_nettype wire

//--- rtl/div.sv
`default_nettype none

module div (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                start_i,
  input  ex_pkg::alu_opcode_e operator_i,
  input  ex_pkg::word_t       dividend_i,
  input  ex_pkg::word_t       divisor_i,

  // Borrowed ALU count and shift
  output logic                div_clz_en_o,
  output ex_pkg::word_t       div_clz_data_o,
  input  ex_pkg::bitcnt_t     div_clz_result_i,
  output logic                div_shift_en_o,
  output ex_pkg::shamt_t      div_shift_amt_o,
  output ex_pkg::word_t       div_shift_data_o,
  input  ex_pkg::word_t       div_shifted_i,

  output logic                busy_o,
  output logic                done_o,
  output ex_pkg::word_t       result_o
);

  import ex_pkg::*;

  typedef enum logic [2:0] {
    DIV_IDLE,
    DIV_CLZ,
    DIV_SHIFT,
    DIV_LOOP,
    DIV_DONE
  } div_state_e;

  div_state_e    state_q;
  logic          op_signed;
  logic          by_zero;
  logic          overflow;
  word_t         a_mag;
  word_t         b_mag;
  logic          rem_sel;
  logic          neg_q;
  logic          neg_r;
  word_t         quo_q;
  word_t         rem_q;
  // Divisor magnitude, then normalised, then walking right
  word_t         dvs_q;
  bitcnt_t       cnt_q;
  logic [XLEN:0] diff;

  assign op_signed = operator_i inside {ALU_DIV, ALU_REM};
  assign a_mag     = (op_signed && dividend_i[XLEN-1]) ? -dividend_i : dividend_i;
  assign b_mag     = (op_signed && divisor_i[XLEN-1]) ? -divisor_i : divisor_i;
  assign by_zero   = (divisor_i == '0);
  // Most negative value over -1
  assign overflow  = op_signed && (dividend_i == {1'b1, {(XLEN-1){1'b0}}}) && (&divisor_i);

  // Trial subtraction, borrow in the top bit
  assign diff = {1'b0, rem_q} - {1'b0, dvs_q};

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= DIV_IDLE;
    end else begin
      unique case (state_q)
        DIV_IDLE:  state_q <= !start_i ? DIV_IDLE :
                              (by_zero || overflow) ? DIV_DONE : DIV_CLZ;
        DIV_CLZ:   state_q <= DIV_SHIFT;
        DIV_SHIFT: state_q <= DIV_LOOP;
        // clz+1 iterations in total
        DIV_LOOP:  state_q <= (cnt_q == '0) ? DIV_DONE : DIV_LOOP;
        default:   state_q <= DIV_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    unique case (state_q)
      DIV_IDLE: begin
        // Reloaded every idle cycle, the start cycle's values stay
        rem_sel <= operator_i inside {ALU_REM, ALU_REMU};
        dvs_q   <= b_mag;
        neg_q   <= op_signed && (dividend_i[XLEN-1] ^ divisor_i[XLEN-1]) && !by_zero;
        neg_r   <= op_signed && dividend_i[XLEN-1] && !by_zero;
        quo_q   <= by_zero ? '1 : overflow ? dividend_i : '0;
        rem_q   <= by_zero ? dividend_i : overflow ? '0 : a_mag;
      end
      DIV_CLZ:   cnt_q <= div_clz_result_i;
      DIV_SHIFT: dvs_q <= div_shifted_i;
      DIV_LOOP: begin
        // Restoring step, one quotient bit
        quo_q <= {quo_q[XLEN-2:0], ~diff[XLEN]};
        if (!diff[XLEN]) begin
          rem_q <= diff[XLEN-1:0];
        end
        dvs_q <= dvs_q >> 1;
        cnt_q <= cnt_q - 1'b1;
      end
      default: ;
    endcase
  end

  assign busy_o = (state_q != DIV_IDLE);
  assign done_o = (state_q == DIV_DONE);

  assign div_clz_en_o     = (state_q == DIV_CLZ);
  assign div_clz_data_o   = dvs_q;
  assign div_shift_en_o   = (state_q == DIV_SHIFT);
  assign div_shift_amt_o  = cnt_q;
  assign div_shift_data_o = dvs_q;

  // Sign fix-up, read out while in DONE
  assign result_o = rem_sel ? (neg_r ? -rem_q : rem_q) : (neg_q ? -quo_q : quo_q);

  // One division at a time
  assert property (@(posedge clk) disable iff (rst_i) start_i |-> !busy_o)
    else $error("Divider started while busy");

endmodule

`default_nettype wire

//--- rtl/ex_stage.sv
`default_nettype none

module ex_stage (
  input  logic            clk,
  input  logic            rst_i,
  input  logic            req_valid_i,
  input  ex_pkg::ex_req_t req_i,
  output logic            rsp_valid_o,
  output ex_pkg::ex_rsp_t rsp_o,
  output logic            busy_o
);

  import ex_pkg::*;

  logic    is_div;
  logic    alu_req;
  word_t   alu_result;
  logic    alu_cmp;
  word_t   div_result;
  logic    div_done;

  // Divider to ALU side ports
  logic    div_clz_en;
  word_t   div_clz_data;
  bitcnt_t div_clz_result;
  logic    div_shift_en;
  shamt_t  div_shift_amt;
  word_t   div_shift_data;
  word_t   div_shifted;

  assign is_div  = req_i.operator inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
  assign alu_req = req_valid_i && !is_div;

  alu alu_i (
    .operator_i          (req_i.operator),
    .operand_a_i         (req_i.operand_a),
    .operand_b_i         (req_i.operand_b),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp),
    .div_clz_en_i        (div_clz_en),
    .div_clz_data_i      (div_clz_data),
    .div_clz_result_o    (div_clz_result),
    .div_shift_en_i      (div_shift_en),
    .div_shift_amt_i     (div_shift_amt),
    .div_shift_data_i    (div_shift_data),
    .div_shifted_o       (div_shifted)
  );

  div div_i (
    .clk              (clk),
    .rst_i            (rst_i),
    .start_i          (req_valid_i && is_div),
    .operator_i       (req_i.operator),
    .dividend_i       (req_i.operand_a),
    .divisor_i        (req_i.operand_b),
    .div_clz_en_o     (div_clz_en),
    .div_clz_data_o   (div_clz_data),
    .div_clz_result_i (div_clz_result),
    .div_shift_en_o   (div_shift_en),
    .div_shift_amt_o  (div_shift_amt),
    .div_shift_data_o (div_shift_data),
    .div_shifted_i    (div_shifted),
    .busy_o           (busy_o),
    .done_o           (div_done),
    .result_o         (div_result)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Response register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= alu_req || div_done;
    end
  end

  // ALU and divider never finish in the same cycle
  always_ff @(posedge clk) begin
    if (div_done) begin
      rsp_o.result <= div_result;
      rsp_o.cmp    <= 1'b0;
    end else if (alu_req) begin
      rsp_o.result <= alu_result;
      rsp_o.cmp    <= alu_cmp;
    end
  end

  // No flow control beyond busy
  assert property (@(posedge clk) disable iff (rst_i) req_valid_i |-> !busy_o)
    else $error("Request issued while divider busy");

endmodule

`default_nettype wire

//--- bench/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Result word by the RISC-V rules, shift amounts are b mod 32
  function automatic word_t ref_result(alu_opcode_e op, word_t a, word_t b);
    int unsigned sh;
    logic        ovf;
    word_t       w;
    sh  = b[4:0];
    // Most negative value over -1
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    w   = '0;
    case (op)
      ALU_ADD:      w = a + b;
      ALU_SUB:      w = a - b;
      ALU_AND:      w = a & b;
      ALU_OR:       w = a | b;
      ALU_XOR:      w = a ^ b;
      ALU_SLL:      w = a << sh;
      ALU_SRL:      w = a >> sh;
      ALU_SRA:      w = $signed(a) >>> sh;
      ALU_SLTS:     w = word_t'($signed(a) < $signed(b));
      ALU_SLTU:     w = word_t'(a < b);
      ALU_B_SH1ADD: w = (a << 1) + b;
      ALU_B_SH2ADD: w = (a << 2) + b;
      ALU_B_SH3ADD: w = (a << 3) + b;
      ALU_B_CLZ: begin
        // Highest set bit wins, zero word stays at 32
        w = word_t'(XLEN);
        for (int i = 0; i < XLEN; i++) begin
          if (a[i]) w = word_t'(XLEN - 1 - i);
        end
      end
      ALU_B_CTZ: begin
        w = word_t'(XLEN);
        for (int i = XLEN - 1; i >= 0; i--) begin
          if (a[i]) w = word_t'(i);
        end
      end
      ALU_B_CPOP: begin
        for (int i = 0; i < XLEN; i++) begin
          w = w + word_t'(a[i]);
        end
      end
      ALU_B_MIN:    w = ($signed(a) < $signed(b)) ? a : b;
      ALU_B_MINU:   w = (a < b) ? a : b;
      ALU_B_MAX:    w = ($signed(a) < $signed(b)) ? b : a;
      ALU_B_MAXU:   w = (a < b) ? b : a;
      ALU_B_ANDN:   w = a & ~b;
      ALU_B_ORN:    w = a | ~b;
      ALU_B_XNOR:   w = ~(a ^ b);
      ALU_B_ORC_B: begin
        for (int i = 0; i < 4; i++) begin
          w[8*i +: 8] = (a[8*i +: 8] != 8'h00) ? 8'hff : 8'h00;
        end
      end
      ALU_B_REV8:   w = {a[7:0], a[15:8], a[23:16], a[31:24]};
      ALU_B_ROL:    w = (a << sh) | (a >> ((XLEN - sh) % XLEN));
      ALU_B_ROR:    w = (a >> sh) | (a << ((XLEN - sh) % XLEN));
      ALU_B_SEXT_B: w = {{24{a[7]}}, a[7:0]};
      ALU_B_SEXT_H: w = {{16{a[15]}}, a[15:0]};
      ALU_B_BSET:   w = a | (word_t'(1) << sh);
      ALU_B_BCLR:   w = a & ~(word_t'(1) << sh);
      ALU_B_BINV:   w = a ^ (word_t'(1) << sh);
      ALU_B_BEXT:   w = word_t'(a[sh]);
      // Zero divisor gives all ones and the dividend back
      ALU_DIVU:     w = (b == '0) ? 32'hffff_ffff : a / b;
      ALU_REMU:     w = (b == '0) ? a : a % b;
      ALU_DIV:      w = (b == '0) ? 32'hffff_ffff : ovf ? a : word_t'($signed(a) / $signed(b));
      ALU_REM:      w = (b == '0) ? a : ovf ? '0 : word_t'($signed(a) % $signed(b));
      default:      w = '0;
    endcase
    return w;
  endfunction

  // Branch outcome for the compare operators
  function automatic logic ref_cmp(alu_opcode_e op, word_t a, word_t b);
    case (op)
      ALU_EQ:  return a == b;
      ALU_NE:  return a != b;
      ALU_LTS: return $signed(a) < $signed(b);
      ALU_LTU: return a < b;
      ALU_GES: return $signed(a) >= $signed(b);
      ALU_GEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_rsp(input string what, input ex_rsp_t got, input ex_rsp_t exp,
                           input logic res_care, input logic cmp_care);
    if (res_care && got.result !== exp.result) begin
      report_failure($sformatf("Error at %0t: %s result %h, expected %h",
                               $time, what, got.result, exp.result));
    end
    if (cmp_care && got.cmp !== exp.cmp) begin
      report_failure($sformatf("Error at %0t: %s cmp %b, expected %b",
                               $time, what, got.cmp, exp.cmp));
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("Error at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

`endif

//--- bench/tb_ex_stage.sv
`default_nettype none

module tb_ex_stage;

  import ex_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int RSP_TIMEOUT  = 50;
  // Galois LFSR taps for x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic        clk;
  logic        rst_i;
  logic        req_valid_i;
  ex_req_t     req_i;
  logic        rsp_valid_o;
  ex_rsp_t     rsp_o;
  logic        busy_o;
  logic [31:0] lfsr_state;

  ex_stage dut_i (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o),
    .busy_o      (busy_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  `include "tb_checks.svh"

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic word_t rand_word();
    word_t w;
    for (int i = 0; i < XLEN; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w[i]       = lfsr_state[0];
    end
    return w;
  endfunction

  // Five LFSR steps for a shift amount of 0 to 31
  function automatic logic [4:0] rand_shift();
    logic [4:0] s;
    for (int i = 0; i < 5; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      s[i]       = lfsr_state[0];
    end
    return s;
  endfunction

  // Inputs change 1 unit after the edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // ALU request with its answer due on the very next cycle
  task automatic alu_op(input alu_opcode_e op, input word_t a, input word_t b);
    ex_rsp_t exp;
    logic    branch;
    string   what;
    what           = $sformatf("%s a=%h b=%h", op.name(), a, b);
    branch         = op inside {ALU_EQ, ALU_NE, ALU_LTS, ALU_LTU, ALU_GES, ALU_GEU};
    exp.result     = ref_result(op, a, b);
    exp.cmp        = ref_cmp(op, a, b);
    req_valid_i    = 1'b1;
    req_i.operator = op;
    req_i.operand_a = a;
    req_i.operand_b = b;
    next_cycle();
    check_bit({what, " rsp_valid_o"}, rsp_valid_o, 1'b1);
    // Branch compares only carry the cmp bit
    check_rsp(what, rsp_o, exp, !branch, branch);
  endtask

  // Drop the strobe and expect the pipe to drain
  task automatic end_burst();
    req_valid_i = 1'b0;
    next_cycle();
    check_bit("rsp_valid_o after burst", rsp_valid_o, 1'b0);
  endtask

  // Division with busy held until the response and a bounded wait
  task automatic div_op(input alu_opcode_e op, input word_t a, input word_t b);
    ex_rsp_t exp;
    string   what;
    int      cycles;
    what            = $sformatf("%s a=%h b=%h", op.name(), a, b);
    exp.result      = ref_result(op, a, b);
    exp.cmp         = 1'b0;
    req_valid_i     = 1'b1;
    req_i.operator  = op;
    req_i.operand_a = a;
    req_i.operand_b = b;
    next_cycle();
    req_valid_i = 1'b0;
    cycles      = 0;
    while (!rsp_valid_o && cycles < RSP_TIMEOUT) begin
      check_bit({what, " busy_o"}, busy_o, 1'b1);
      next_cycle();
      cycles++;
    end
    if (!rsp_valid_o) begin
      report_failure($sformatf("Timeout: no response to %s within %0d cycles",
                               what, RSP_TIMEOUT));
    end
    check_bit({what, " busy_o at response"}, busy_o, 1'b0);
    check_rsp(what, rsp_o, exp, 1'b1, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_logic_burst();
    alu_opcode_e ops [11] = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_B_ANDN,
                              ALU_B_ORN, ALU_B_XNOR, ALU_B_SH1ADD, ALU_B_SH2ADD,
                              ALU_B_SH3ADD};
    check_bit("rsp_valid_o after reset", rsp_valid_o, 1'b0);
    check_bit("busy_o after reset", busy_o, 1'b0);
    for (int r = 0; r < 8; r++) begin
      foreach (ops[i]) begin
        alu_op(ops[i], rand_word(), rand_word());
      end
    end
    end_burst();
  endtask

  task automatic test_shifts();
    alu_opcode_e ops [9] = '{ALU_SLL, ALU_SRL, ALU_SRA, ALU_B_ROL, ALU_B_ROR,
                             ALU_B_BSET, ALU_B_BCLR, ALU_B_BINV, ALU_B_BEXT};
    // Upper bits of the amount must not matter
    word_t       amts [4] = '{32'd0, 32'd31, 32'd32, 32'hffff_ffe1};
    for (int r = 0; r < 8; r++) begin
      foreach (ops[i]) begin
        alu_op(ops[i], rand_word(), rand_word());
      end
    end
    foreach (amts[k]) begin
      foreach (ops[i]) begin
        alu_op(ops[i], rand_word(), amts[k]);
      end
    end
    end_burst();
  endtask

  task automatic test_compares();
    alu_opcode_e ops [12] = '{ALU_EQ, ALU_NE, ALU_LTS, ALU_LTU, ALU_GES, ALU_GEU,
                              ALU_SLTS, ALU_SLTU, ALU_B_MIN, ALU_B_MINU, ALU_B_MAX,
                              ALU_B_MAXU};
    // Sign boundary corners plus one random word
    word_t       vals [6] = '{32'h0, 32'h1, 32'h7fff_ffff, 32'h8000_0000,
                              32'hffff_ffff, 32'h0};
    vals[5] = rand_word();
    foreach (vals[x]) begin
      foreach (vals[y]) begin
        foreach (ops[i]) begin
          alu_op(ops[i], vals[x], vals[y]);
        end
      end
    end
    end_burst();
  endtask

  task automatic test_counts();
    alu_opcode_e ops [7] = '{ALU_B_CLZ, ALU_B_CTZ, ALU_B_CPOP, ALU_B_ORC_B, ALU_B_REV8,
                             ALU_B_SEXT_B, ALU_B_SEXT_H};
    word_t       vals [6] = '{32'h0, 32'h1, 32'h8000_0000, 32'hffff_ffff,
                              32'h0001_8000, 32'h0000_8080};
    word_t       a;
    for (int r = 0; r < 14; r++) begin
      if (r < 6) begin
        a = vals[r];
      end else begin
        a = rand_word();
      end
      foreach (ops[i]) begin
        alu_op(ops[i], a, rand_word());
      end
    end
    end_burst();
  endtask

  task automatic test_divide();
    alu_opcode_e ops [4] = '{ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
    word_t       a [15];
    word_t       b [15];
    logic [4:0]  sh;
    foreach (ops[i]) begin
      // Zero divisor, signed overflow and zero dividend come first
      a[0] = rand_word();
      b[0] = '0;
      a[1] = 32'h8000_0000;
      b[1] = 32'hffff_ffff;
      a[2] = '0;
      b[2] = rand_word();
      for (int n = 3; n < 15; n++) begin
        a[n] = rand_word();
        if (n < 9) begin
          b[n] = rand_word();
        end else begin
          // Short divisors give long loops
          sh   = rand_shift();
          b[n] = rand_word() >> sh;
        end
      end
      foreach (a[n]) begin
        div_op(ops[i], a[n], b[n]);
        // ALU request right on the response cycle
        alu_op(ALU_ADD, rand_word(), rand_word());
        end_burst();
      end
    end
  endtask

  initial begin
    lfsr_state  = 32'd5;
    rst_i       = 1'b1;
    req_valid_i = 1'b0;
    req_i       = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_i = 1'b0;
    test_logic_burst();
    test_shifts();
    test_compares();
    test_counts();
    test_divide();
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- ex_stage.f
+incdir+bench
rtl/ex_pkg.sv
rtl/ff_one.sv
rtl/alu_b_cpop.sv
rtl/alu.sv
rtl/div.sv
rtl/ex_stage.sv
bench/tb_ex_stage.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the ex_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ex_stage --Mdir "$build_dir" -o Vtb_ex_stage \
    -f ex_stage.f; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/Vtb_ex_stage" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Finished with no errors$" "$log_file"; then
  echo "PASS"
  exit 0
fi

echo "FAIL"
exit 1
